//--- all.f
common/soc_bus_pkg.sv
common/soc_map_pkg.sv
hw/rst_sync.sv
hw/debug_gate.sv
hw/interconnect/addr_decode.sv
hw/interconnect/bus_demux.sv
hw/mem/sram.sv
hw/mem/bootrom.sv
hw/soc_subsystem.sv
testbench/soc_subsystem_props.sv
testbench/tb_soc_subsystem.sv

//--- common/soc_bus_pkg.sv
package soc_bus_pkg;

  // --------------------------------------------------------------------
  // Bus widths and types
  // --------------------------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] be_t;

  // Same encoding as the AXI response field
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  // Read word returned by the stub region
  localparam data_t ErrReadData = data_t'(32'hdeadbeef);

  // --------------------------------------------------------------------
  // Reset and debug timing
  // --------------------------------------------------------------------
  // Boot code gets this many cycles before a debug halt
  localparam int unsigned DebugDelayCycles = 500;
  localparam int unsigned DebugCntWidth    = $clog2(DebugDelayCycles + 1);

  localparam int unsigned RstSyncStages = 2;

endpackage

//--- common/soc_map_pkg.sv
package soc_map_pkg;

  import soc_bus_pkg::*;

  // --------------------------------------------------------------------
  // Slaves and address rules
  // --------------------------------------------------------------------
  typedef enum logic [1:0] {
    SLV_ROM  = 2'd0,
    SLV_DRAM = 2'd1,
    SLV_STUB = 2'd2
  } slave_idx_e;

  localparam int unsigned NrSlaves = 3;

  // Start inclusive, end exclusive
  typedef struct packed {
    slave_idx_e idx;
    addr_t      start_addr;
    addr_t      end_addr;
  } addr_rule_t;

  localparam addr_t RomBase    = 32'h0001_0000;
  localparam addr_t RomLength  = 32'h80;
  localparam addr_t DramBase   = 32'h8000_0000;
  localparam addr_t DramLength = 32'h1000;
  // GPIO window, answered by the stub
  localparam addr_t StubBase   = 32'h4000_0000;
  localparam addr_t StubLength = 32'h1000;

  localparam addr_rule_t AddrMap [NrSlaves] = '{
    '{idx: SLV_ROM,  start_addr: RomBase,  end_addr: RomBase + RomLength},
    '{idx: SLV_DRAM, start_addr: DramBase, end_addr: DramBase + DramLength},
    '{idx: SLV_STUB, start_addr: StubBase, end_addr: StubBase + StubLength}
  };

  // --------------------------------------------------------------------
  // Memories
  // --------------------------------------------------------------------
  localparam int unsigned RomWords     = 16;
  localparam int unsigned DramWords    = 512;
  localparam int unsigned WordOffset   = 3;
  localparam int unsigned RomIdxWidth  = $clog2(RomWords);
  localparam int unsigned DramIdxWidth = $clog2(DramWords);

  // Relative to the simulation working directory
  localparam string BootFile = "hw/mem/boot.hex";

endpackage

//--- hw/debug_gate.sv
`timescale 1ns/1ps

module debug_gate
  import soc_bus_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  output logic debug_req_o
);

  logic [DebugCntWidth-1:0] cnt_d;
  logic [DebugCntWidth-1:0] cnt_q;
  logic                     window_done;

  assign window_done = (cnt_q == '0);

  // Count down and stick at zero
  assign cnt_d = window_done ? cnt_q : cnt_q - 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= DebugCntWidth'(DebugDelayCycles);
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Request held off while boot code runs
  assign debug_req_o = window_done & debug_req_i;

endmodule

//--- hw/interconnect/addr_decode.sv
`timescale 1ns/1ps

module addr_decode
  import soc_bus_pkg::*;
  import soc_map_pkg::*;
(
  input  addr_t      addr_i,
  output logic       hit_o,
  output slave_idx_e idx_o
);

  // Regions do not overlap, so the first match is the only one
  always_comb begin
    hit_o = 1'b0;
    idx_o = SLV_ROM;
    for (int unsigned i = 0; i < NrSlaves; i++) begin
      if (!hit_o && addr_i >= AddrMap[i].start_addr &&
          addr_i < AddrMap[i].end_addr) begin
        hit_o = 1'b1;
        idx_o = AddrMap[i].idx;
      end
    end
  end

endmodule

//--- hw/interconnect/bus_demux.sv
`timescale 1ns/1ps

module bus_demux
  import soc_bus_pkg::*;
  import soc_map_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    bus_req_i,
  input  logic                    bus_we_i,
  input  addr_t                   bus_addr_i,
  input  be_t                     bus_be_i,
  input  data_t                   bus_wdata_i,
  output logic                    bus_rvalid_o,
  output data_t                   bus_rdata_o,
  output resp_e                   bus_resp_o,
  output logic                    rom_req_o,
  output logic                    dram_req_o,
  output logic                    mem_we_o,
  output logic [DramIdxWidth-1:0] mem_word_o,
  output be_t                     mem_be_o,
  output data_t                   mem_wdata_o,
  input  data_t                   rom_rdata_i,
  input  data_t                   dram_rdata_i
);

  logic       dec_hit;
  slave_idx_e dec_idx;
  addr_t      offset;
  resp_e      resp_d;

  logic       valid_q;
  slave_idx_e idx_q;
  logic       we_q;
  resp_e      resp_q;

  addr_decode i_addr_decode (
    .addr_i ( bus_addr_i ),
    .hit_o  ( dec_hit    ),
    .idx_o  ( dec_idx    )
  );

  // --------------------------------------------------------------------
  // Request side
  // --------------------------------------------------------------------
  // No memory access while the subsystem is held in reset
  assign rom_req_o  = rst_ni & bus_req_i & dec_hit & (dec_idx == SLV_ROM);
  assign dram_req_o = rst_ni & bus_req_i & dec_hit & (dec_idx == SLV_DRAM);

  // Word index relative to the region base
  assign offset      = bus_addr_i - AddrMap[dec_idx].start_addr;
  assign mem_word_o  = offset[WordOffset +: DramIdxWidth];
  assign mem_we_o    = bus_we_i;
  assign mem_be_o    = bus_be_i;
  assign mem_wdata_o = bus_wdata_i;

  always_comb begin
    if (!dec_hit) begin
      resp_d = RESP_DECERR;
    end else if (dec_idx == SLV_STUB) begin
      resp_d = RESP_SLVERR;
    end else begin
      resp_d = RESP_OKAY;
    end
  end

  // --------------------------------------------------------------------
  // Response side
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      idx_q   <= SLV_ROM;
      we_q    <= 1'b0;
      resp_q  <= RESP_OKAY;
    end else begin
      valid_q <= bus_req_i;
      if (bus_req_i) begin
        idx_q  <= dec_idx;
        we_q   <= bus_we_i;
        resp_q <= resp_d;
      end
    end
  end

  // Memories return data in this cycle, errors are answered here
  always_comb begin
    bus_rdata_o = '0;
    if (!we_q && resp_q != RESP_DECERR) begin
      case (idx_q)
        SLV_ROM:  bus_rdata_o = rom_rdata_i;
        SLV_DRAM: bus_rdata_o = dram_rdata_i;
        default:  bus_rdata_o = ErrReadData;
      endcase
    end
  end

  assign bus_rvalid_o = valid_q;
  assign bus_resp_o   = resp_q;

endmodule

//--- hw/mem/boot.hex
// Boot ROM image: one 64-bit word per line, word index 0 to 15
0002829300000297
0000011300000093
0182829300000193
0182b02300010137
f140257300028067
0005846300000597
0000006f10500073
00c5b28300053283
00d5b0230055b023
fff2829300100313
0001050300628463
0083031300000013
00a3202300001537
0000000000000073
cafe0000f00d0001
b007c0de5eed0002

//--- hw/mem/bootrom.sv
`timescale 1ns/1ps

module bootrom
  import soc_bus_pkg::*;
  import soc_map_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   req_i,
  input  logic [RomIdxWidth-1:0] word_i,
  output data_t                  rdata_o
);

  data_t mem [RomWords];

  initial begin
    $readmemh(BootFile, mem);
  end

  // No write port, writes just read the word
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= mem[word_i];
    end
  end

endmodule

//--- hw/mem/sram.sv
`timescale 1ns/1ps

module sram
  import soc_bus_pkg::*;
  import soc_map_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    req_i,
  input  logic                    we_i,
  input  logic [DramIdxWidth-1:0] word_i,
  input  be_t                     be_i,
  input  data_t                   wdata_i,
  output data_t                   rdata_o
);

  data_t mem [DramWords];

  // Single port, read and write share the strobe
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int unsigned b = 0; b < StrbWidth; b++) begin
          if (be_i[b]) begin
            mem[word_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem[word_i];
      end
    end
  end

endmodule

//--- hw/rst_sync.sv
`timescale 1ns/1ps

module rst_sync
  import soc_bus_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  output logic rst_no
);

  logic                     rst_comb_n;
  logic [RstSyncStages-1:0] sync_q;

  // Either source asserts at once
  assign rst_comb_n = rst_ni & ~ndmreset_i;

  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[RstSyncStages-2:0], 1'b1};
    end
  end

  assign rst_no = sync_q[RstSyncStages-1];

endmodule

//--- hw/soc_subsystem.sv
`timescale 1ns/1ps

module soc_subsystem
  import soc_bus_pkg::*;
  import soc_map_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  ndmreset_i,
  input  logic  debug_req_i,
  input  logic  bus_req_i,
  input  logic  bus_we_i,
  input  addr_t bus_addr_i,
  input  be_t   bus_be_i,
  input  data_t bus_wdata_i,
  output logic  rst_no,
  output logic  debug_req_o,
  output logic  bus_rvalid_o,
  output data_t bus_rdata_o,
  output resp_e bus_resp_o
);

  logic                    rst_int_n;
  logic                    rom_req;
  logic                    dram_req;
  logic                    mem_we;
  logic [DramIdxWidth-1:0] mem_word;
  be_t                     mem_be;
  data_t                   mem_wdata;
  data_t                   rom_rdata;
  data_t                   dram_rdata;

  // --------------------------------------------------------------------
  // Reset and debug
  // --------------------------------------------------------------------
  rst_sync i_rst_sync (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .ndmreset_i ( ndmreset_i ),
    .rst_no     ( rst_int_n  )
  );

  assign rst_no = rst_int_n;

  // Power-on reset only, ndmreset leaves the window alone
  debug_gate i_debug_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

  // --------------------------------------------------------------------
  // Interconnect
  // --------------------------------------------------------------------
  bus_demux i_bus_demux (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_int_n    ),
    .bus_req_i    ( bus_req_i    ),
    .bus_we_i     ( bus_we_i     ),
    .bus_addr_i   ( bus_addr_i   ),
    .bus_be_i     ( bus_be_i     ),
    .bus_wdata_i  ( bus_wdata_i  ),
    .bus_rvalid_o ( bus_rvalid_o ),
    .bus_rdata_o  ( bus_rdata_o  ),
    .bus_resp_o   ( bus_resp_o   ),
    .rom_req_o    ( rom_req      ),
    .dram_req_o   ( dram_req     ),
    .mem_we_o     ( mem_we       ),
    .mem_word_o   ( mem_word     ),
    .mem_be_o     ( mem_be       ),
    .mem_wdata_o  ( mem_wdata    ),
    .rom_rdata_i  ( rom_rdata    ),
    .dram_rdata_i ( dram_rdata   )
  );

  // --------------------------------------------------------------------
  // Memories
  // --------------------------------------------------------------------
  bootrom i_bootrom (
    .clk_i   ( clk_i                      ),
    .req_i   ( rom_req                    ),
    .word_i  ( mem_word[RomIdxWidth-1:0]  ),
    .rdata_o ( rom_rdata                  )
  );

  sram i_sram (
    .clk_i   ( clk_i      ),
    .req_i   ( dram_req   ),
    .we_i    ( mem_we     ),
    .word_i  ( mem_word   ),
    .be_i    ( mem_be     ),
    .wdata_i ( mem_wdata  ),
    .rdata_o ( dram_rdata )
  );

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f all.f --top-module tb_soc_subsystem -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi

//--- testbench/soc_subsystem_props.sv
`timescale 1ns/1ps

module soc_subsystem_props (
  input logic clk_i,
  input logic rst_ni,
  input logic req_i,
  input logic rvalid_i,
  input logic rom_req_i,
  input logic dram_req_i,
  input logic dec_hit_i
);

  // Fixed one-cycle latency
  a_req_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |=> rvalid_i)
    else $error("request got no response one cycle later");

  a_one_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rom_req_i && dram_req_i))
    else $error("ROM and SRAM strobes high together");

  a_decerr_no_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i && !dec_hit_i) |-> !(rom_req_i || dram_req_i))
    else $error("unmapped access raised a memory strobe");

endmodule

bind bus_demux soc_subsystem_props i_props (
  .clk_i      ( clk_i        ),
  .rst_ni     ( rst_ni       ),
  .req_i      ( bus_req_i    ),
  .rvalid_i   ( bus_rvalid_o ),
  .rom_req_i  ( rom_req_o    ),
  .dram_req_i ( dram_req_o   ),
  .dec_hit_i  ( dec_hit      )
);

//--- testbench/tb_soc_subsystem.sv
`timescale 1ns/1ps

module tb_clk #(
  parameter int unsigned Period = 40
) (
  output logic clk_o
);
  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end
endmodule

module tb_soc_subsystem
  import soc_bus_pkg::*;
  import soc_map_pkg::*;
();

  localparam int unsigned SramBurst = 16;
  localparam int unsigned MixRounds = 8;
  localparam int unsigned TimeoutCycles = 2 + RstSyncStages + DebugDelayCycles
                                          + 3 * SramBurst + 2 * RomWords + 4 * MixRounds + 100;

  logic  clk_i, rst_ni, ndmreset_i, debug_req_i, bus_req_i, bus_we_i;
  addr_t bus_addr_i;
  be_t   bus_be_i;
  data_t bus_wdata_i;
  logic  rst_no, debug_req_o, bus_rvalid_o;
  data_t bus_rdata_o;
  resp_e bus_resp_o;

  int          seed = 32'h349c_00cf;
  int unsigned errors = 0;
  int unsigned checks = 0;
  int unsigned neg_cnt = 0;
  int unsigned dbg_edges = 0;
  data_t       rom_image [RomWords];
  data_t       dram_shadow [DramWords];
  string       name_q [$];
  logic [97:0] exp_q [$];

  tb_clk #(.Period(40)) i_clk (.clk_o(clk_i));

  soc_subsystem dut0 (.*);

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // Expected {resp, data} from the region rules and the shadow memories
  function automatic logic [DataWidth+1:0] ref_response(input logic we, input addr_t addr);
    resp_e resp;
    data_t data;
    resp = RESP_DECERR;
    data = '0;
    if (addr >= RomBase && addr < RomBase + RomLength) begin
      resp = RESP_OKAY;
      data = rom_image[(addr - RomBase) >> WordOffset];
    end else if (addr >= DramBase && addr < DramBase + DramLength) begin
      resp = RESP_OKAY;
      data = dram_shadow[(addr - DramBase) >> WordOffset];
    end else if (addr >= StubBase && addr < StubBase + StubLength) begin
      resp = RESP_SLVERR;
      data = ErrReadData;
    end
    if (we) begin
      data = '0;
    end
    return {resp, data};
  endfunction

  function automatic addr_t dram_addr(input int unsigned word);
    return DramBase + addr_t'(word << WordOffset);
  endfunction

  task automatic bus_access(input string name, input logic we, input addr_t addr,
                            input be_t be, input data_t wdata);
    int unsigned word;
    @(posedge clk_i);
    bus_req_i   <= 1'b1;
    bus_we_i    <= we;
    bus_addr_i  <= addr;
    bus_be_i    <= be;
    bus_wdata_i <= wdata;
    // Response shows up two negedges from now
    name_q.push_back(name);
    exp_q.push_back({neg_cnt + 32'd2, ref_response(we, addr)});
    if (we && addr >= DramBase && addr < DramBase + DramLength) begin
      word = (addr - DramBase) >> WordOffset;
      for (int b = 0; b < StrbWidth; b++) begin
        if (be[b]) begin
          dram_shadow[word][b*8 +: 8] = wdata[b*8 +: 8];
        end
      end
    end
  endtask

  task automatic bus_idle();
    @(posedge clk_i);
    bus_req_i <= 1'b0;
    bus_we_i  <= 1'b0;
  endtask

  // --------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------
  initial begin : stimulus
    int unsigned idx [SramBurst];
    addr_t       miss [4];
    rst_ni      = 1'b0;
    ndmreset_i  = 1'b0;
    debug_req_i = 1'b1;
    bus_req_i   = 1'b0;
    bus_we_i    = 1'b0;
    bus_addr_i  = '0;
    bus_be_i    = '0;
    bus_wdata_i = '0;
    miss = '{RomBase + RomLength, DramBase + DramLength, 32'h2000_0000, StubBase - 32'h8};
    $readmemh("hw/mem/boot.hex", rom_image);
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    do @(negedge clk_i); while (!rst_no);

    // SRAM fill, then byte-merge pass, then readback
    for (int i = 0; i < SramBurst; i++) begin
      idx[i] = $unsigned($random(seed)) % DramWords;
      bus_access("sram_fill", 1'b1, dram_addr(idx[i]), '1, {$random(seed), $random(seed)});
    end
    for (int i = 0; i < SramBurst; i++) begin
      bus_access("sram_merge", 1'b1, dram_addr(idx[i]), be_t'($random(seed)),
                 {$random(seed), $random(seed)});
    end
    for (int i = 0; i < SramBurst; i++) begin
      bus_access("sram_read", 1'b0, dram_addr(idx[i]), '1, '0);
    end
    bus_idle();

    for (int i = 0; i < RomWords; i++) begin
      bus_access("rom_read", 1'b0, RomBase + addr_t'(i << WordOffset), '1, '0);
    end
    bus_access("rom_write", 1'b1, RomBase + 32'h18, '1, {$random(seed), $random(seed)});
    bus_idle();
    bus_access("rom_reread", 1'b0, RomBase + 32'h18, '1, '0);

    // Error regions mixed with SRAM traffic, no idle cycles
    for (int i = 0; i < MixRounds; i++) begin
      bus_access("stub_read", 1'b0, StubBase + (addr_t'($random(seed)) & 32'hff8), '1, '0);
      bus_access("sram_mix_read", 1'b0, dram_addr(idx[i]), '1, '0);
      bus_access("miss_access", i[0], miss[i % 4], '1, '0);
      bus_access("sram_mix_write", 1'b1, dram_addr(idx[i]), be_t'($random(seed)),
                 {$random(seed), $random(seed)});
    end
    bus_idle();

    wait (dbg_edges >= DebugDelayCycles + 4);
    for (int i = 0; i < 4; i++) begin
      bus_access("pre_reset_write", 1'b1, dram_addr(idx[i]), '1, {$random(seed), $random(seed)});
    end
    bus_idle();
    @(posedge clk_i);
    ndmreset_i <= 1'b1;
    @(negedge clk_i);
    check_value("rst_no_assert", 1'b0, rst_no);
    // Write during reset that must leave the SRAM alone
    @(posedge clk_i);
    bus_req_i   <= 1'b1;
    bus_we_i    <= 1'b1;
    bus_addr_i  <= dram_addr(idx[0]);
    bus_be_i    <= '1;
    bus_wdata_i <= ~dram_shadow[idx[0]];
    @(posedge clk_i);
    bus_req_i   <= 1'b0;
    bus_we_i    <= 1'b0;
    @(posedge clk_i);
    ndmreset_i <= 1'b0;
    for (int i = 1; i <= RstSyncStages; i++) begin
      @(posedge clk_i);
      @(negedge clk_i);
      check_value("rst_no_release", i == RstSyncStages, rst_no);
    end
    for (int i = 0; i < 4; i++) begin
      bus_access("post_reset_read", 1'b0, dram_addr(idx[i]), '1, '0);
    end
    bus_idle();
    repeat (3) @(posedge clk_i);

    if (name_q.size() != 0) begin
      errors++;
      $display("%0d expected responses never arrived", name_q.size());
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // --------------------------------------------------------------------
  // Response compare, debug window and watchdog
  // --------------------------------------------------------------------
  initial begin : response_compare
    string       name;
    logic [97:0] exp;
    forever begin
      @(negedge clk_i);
      neg_cnt++;
      if (bus_rvalid_o) begin
        if (name_q.size() == 0) begin
          errors++;
          $display("Response at cycle %0d with no request outstanding", neg_cnt);
        end else begin
          name = name_q.pop_front();
          exp  = exp_q.pop_front();
          check_value({name, "_latency"}, exp[97:66], neg_cnt);
          check_value({name, "_resp"}, exp[65:64], bus_resp_o);
          check_value({name, "_data"}, exp[63:0], bus_rdata_o);
        end
      end
    end
  end

  // Edge k after rst_ni rises leaves DebugDelayCycles - k in the window
  initial begin : debug_window_check
    @(posedge rst_ni);
    forever begin
      @(negedge clk_i);
      check_value("debug_req", dbg_edges >= DebugDelayCycles, debug_req_o);
      @(posedge clk_i);
      dbg_edges++;
    end
  end

  initial begin : watchdog
    repeat (TimeoutCycles) @(posedge clk_i);
    $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
    $display("Test failed");
    $finish;
  end

endmodule
